// ==== source/sm83_params.svh ====
`ifndef SM83_PARAMS_SVH
`define SM83_PARAMS_SVH

// Datapath widths
`define SM83_DATA_W     8
`define SM83_REG_IDX_W  3

// Register indices as encoded in the opcode fields
`define SM83_REG_A       3'd7
`define SM83_REG_HL_IND  3'd6   // (HL) operand slot

// Opcode bits 7:6
`define SM83_GRP_MISC     2'd0
`define SM83_GRP_LD       2'd1
`define SM83_GRP_ALU_R    2'd2
`define SM83_GRP_ALU_IMM  2'd3

// ALU operation, opcode bits 5:3
`define SM83_OP_ADD  3'd0
`define SM83_OP_ADC  3'd1
`define SM83_OP_SUB  3'd2
`define SM83_OP_SBC  3'd3
`define SM83_OP_AND  3'd4
`define SM83_OP_XOR  3'd5
`define SM83_OP_OR   3'd6
`define SM83_OP_CP   3'd7

`define SM83_OPC_HALT  8'h76

// Z N H C
`define SM83_FLAGS_RESET  4'b1000

`endif

// ==== source/sm83_pkg.sv ====
`default_nettype none

`include "sm83_params.svh"

package sm83_pkg;

    typedef logic [`SM83_DATA_W-1:0]    byte_t;
    typedef logic [`SM83_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]                 alu_op_t;
    typedef logic [3:0]                 flags_t;   // Z N H C

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_RELEASE
    } hs_state_t;

    typedef enum logic {
        RX_IDLE,
        RX_ACK
    } rx_state_t;

endpackage

`default_nettype wire

// ==== source/instr_intake.sv ====
`default_nettype none
`timescale 1ns/1ps

module instr_intake
    import sm83_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  in_req,
    input  byte_t in_opcode,
    input  byte_t in_imm,
    output logic  in_ack,
    input  logic  inst_take,
    output logic  inst_valid,
    output byte_t inst_opcode,
    output byte_t inst_imm
);

    rx_state_t rx_state;
    logic      buf_full;
    byte_t     opcode_buf;
    byte_t     imm_buf;
    logic      capture;

    // New request accepted only with room in the buffer
    assign capture = (rx_state == RX_IDLE) && in_req && !buf_full;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            rx_state <= RX_IDLE;
            buf_full <= 1'b0;
        end
        else
        begin
            case (rx_state)
                RX_IDLE:
                begin
                    if (capture)
                        rx_state <= RX_ACK;
                end
                RX_ACK:
                begin
                    if (!in_req)
                        rx_state <= RX_IDLE;   // Host released, drop ack
                end
                default: rx_state <= RX_IDLE;
            endcase

            if (inst_take)
                buf_full <= 1'b0;
            else if (capture)
                buf_full <= 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (capture)
        begin
            opcode_buf <= in_opcode;
            imm_buf    <= in_imm;
        end
    end

    assign in_ack      = (rx_state == RX_ACK);
    assign inst_valid  = buf_full;
    assign inst_opcode = opcode_buf;
    assign inst_imm    = imm_buf;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file
    import sm83_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output byte_t    rd_data_a,
    output byte_t    rd_data_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  byte_t    wr_data
);

    // B C D E H L (HL) A
    byte_t regs [0:7];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            regs <= '{default: '0};
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Reads see the old value during a write cycle
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== source/sm83_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "sm83_params.svh"

module sm83_alu
    import sm83_pkg::*;
(
    input  byte_t   a,
    input  byte_t   b,
    input  logic    carry_in,
    input  alu_op_t op,
    output byte_t   result,
    output flags_t  flags
);

    logic       cin;
    logic [8:0] sum;
    logic [8:0] diff;
    logic [4:0] sum_lo;
    logic [4:0] diff_lo;
    byte_t      value;
    logic       n_flag;
    logic       h_flag;
    logic       c_flag;

    // Carry only feeds ADC and SBC
    assign cin = ((op == `SM83_OP_ADC) || (op == `SM83_OP_SBC)) ? carry_in : 1'b0;

    assign sum     = {1'b0, a} + {1'b0, b} + {8'd0, cin};
    assign diff    = {1'b0, a} - {1'b0, b} - {8'd0, cin};
    assign sum_lo  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};   // Bit 4 is half carry
    assign diff_lo = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};   // Bit 4 is half borrow

    always_comb
    begin
        value  = sum[7:0];
        n_flag = 1'b0;
        h_flag = 1'b0;
        c_flag = 1'b0;
        case (op)
            `SM83_OP_ADD, `SM83_OP_ADC:
            begin
                value  = sum[7:0];
                h_flag = sum_lo[4];
                c_flag = sum[8];
            end
            `SM83_OP_SUB, `SM83_OP_SBC, `SM83_OP_CP:
            begin
                value  = diff[7:0];
                n_flag = 1'b1;
                h_flag = diff_lo[4];
                c_flag = diff[8];
            end
            `SM83_OP_AND:
            begin
                value  = a & b;
                h_flag = 1'b1;
            end
            `SM83_OP_XOR:
            begin
                value = a ^ b;
            end
            `SM83_OP_OR:
            begin
                value = a | b;
            end
        endcase
    end

    // CP keeps A, but Z still comes from the difference
    assign result = (op == `SM83_OP_CP) ? a : value;
    assign flags  = {(value == 8'd0), n_flag, h_flag, c_flag};

endmodule

`default_nettype wire

// ==== source/sm83_execute.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "sm83_params.svh"

module sm83_execute
    import sm83_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  logic   inst_valid,
    input  byte_t  inst_opcode,
    input  byte_t  inst_imm,
    output logic   inst_take,
    input  logic   slot_full,
    output logic   result_load,
    output byte_t  result_data,
    output flags_t result_flags
);

    logic [1:0] op_group;
    reg_idx_t   dst_idx;
    reg_idx_t   src_idx;
    alu_op_t    alu_op;
    logic       is_ld_imm;
    logic       is_ld_reg;
    logic       is_alu_reg;
    logic       is_alu_imm;
    logic       is_alu;
    logic       fire;
    logic       wr_en;
    reg_idx_t   wr_idx;
    byte_t      a_data;
    byte_t      src_data;
    byte_t      alu_b;
    byte_t      alu_result;
    flags_t     alu_flags;
    flags_t     flag_q;

    assign op_group = inst_opcode[7:6];
    assign dst_idx  = inst_opcode[5:3];
    assign src_idx  = inst_opcode[2:0];
    assign alu_op   = inst_opcode[5:3];

    // Instruction classes, everything else is a no-op
    assign is_ld_imm  = (op_group == `SM83_GRP_MISC) && (src_idx == `SM83_REG_HL_IND)
                        && (dst_idx != `SM83_REG_HL_IND);
    assign is_ld_reg  = (op_group == `SM83_GRP_LD) && (dst_idx != `SM83_REG_HL_IND)
                        && (src_idx != `SM83_REG_HL_IND) && (inst_opcode != `SM83_OPC_HALT);
    assign is_alu_reg = (op_group == `SM83_GRP_ALU_R) && (src_idx != `SM83_REG_HL_IND);
    assign is_alu_imm = (op_group == `SM83_GRP_ALU_IMM) && (src_idx == `SM83_REG_HL_IND);
    assign is_alu     = is_alu_reg || is_alu_imm;

    // Execute as soon as the result slot can take the outcome
    assign fire        = inst_valid && !slot_full;
    assign inst_take   = fire;
    assign result_load = fire;

    reg_file u_reg_file (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_idx_a  (`SM83_REG_A),
        .rd_idx_b  (src_idx),
        .rd_data_a (a_data),
        .rd_data_b (src_data),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (result_data)
    );

    assign alu_b = is_alu_imm ? inst_imm : src_data;

    sm83_alu u_alu (
        .a        (a_data),
        .b        (alu_b),
        .carry_in (flag_q[0]),
        .op       (alu_op),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    // CP only touches the flags
    assign wr_en  = fire && (is_ld_imm || is_ld_reg || (is_alu && (alu_op != `SM83_OP_CP)));
    assign wr_idx = is_alu ? `SM83_REG_A : dst_idx;

    always_comb
    begin
        if (is_ld_imm)
            result_data = inst_imm;
        else if (is_ld_reg)
            result_data = src_data;
        else if (is_alu)
            result_data = alu_result;   // A itself for CP
        else
            result_data = a_data;
    end

    assign result_flags = is_alu ? alu_flags : flag_q;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            flag_q <= `SM83_FLAGS_RESET;
        else if (fire && is_alu)
            flag_q <= alu_flags;
    end

endmodule

`default_nettype wire

// ==== source/result_port.sv ====
`default_nettype none
`timescale 1ns/1ps

module result_port
    import sm83_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  logic   result_load,
    input  byte_t  result_data,
    input  flags_t result_flags,
    output logic   slot_full,
    output logic   out_req,
    input  logic   out_ack,
    output byte_t  out_data,
    output flags_t out_flags
);

    hs_state_t hs_state;
    byte_t     data_q;
    flags_t    flags_q;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            hs_state <= HS_IDLE;
        end
        else
        begin
            case (hs_state)
                HS_IDLE:
                begin
                    if (result_load)
                        hs_state <= HS_REQ;
                end
                HS_REQ:
                begin
                    if (out_ack)
                        hs_state <= HS_RELEASE;   // Consumer has the data
                end
                HS_RELEASE:
                begin
                    if (!out_ack)
                        hs_state <= HS_IDLE;
                end
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

    // Payload held until the next load
    always_ff @(posedge clock)
    begin
        if (result_load && (hs_state == HS_IDLE))
        begin
            data_q  <= result_data;
            flags_q <= result_flags;
        end
    end

    assign slot_full = (hs_state != HS_IDLE);
    assign out_req   = (hs_state == HS_REQ);
    assign out_data  = data_q;
    assign out_flags = flags_q;

endmodule

`default_nettype wire

// ==== source/sm83_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module sm83_core (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           in_req,
    input  sm83_pkg::byte_t in_opcode,
    input  sm83_pkg::byte_t in_imm,
    output logic           in_ack,
    output logic           out_req,
    input  logic           out_ack,
    output sm83_pkg::byte_t out_data,
    output sm83_pkg::byte_t out_flags
);

    logic            inst_valid;
    logic            inst_take;
    sm83_pkg::byte_t inst_opcode;
    sm83_pkg::byte_t inst_imm;
    logic            slot_full;
    logic            result_load;
    sm83_pkg::byte_t result_data;
    logic [3:0]      result_flags;
    logic [3:0]      port_flags;

    instr_intake u_intake (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_opcode   (in_opcode),
        .in_imm      (in_imm),
        .in_ack      (in_ack),
        .inst_take   (inst_take),
        .inst_valid  (inst_valid),
        .inst_opcode (inst_opcode),
        .inst_imm    (inst_imm)
    );

    sm83_execute u_execute (
        .clock        (clock),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst_opcode  (inst_opcode),
        .inst_imm     (inst_imm),
        .inst_take    (inst_take),
        .slot_full    (slot_full),
        .result_load  (result_load),
        .result_data  (result_data),
        .result_flags (result_flags)
    );

    result_port u_result (
        .clock        (clock),
        .rst_n        (rst_n),
        .result_load  (result_load),
        .result_data  (result_data),
        .result_flags (result_flags),
        .slot_full    (slot_full),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_data     (out_data),
        .out_flags    (port_flags)
    );

    // Flag byte, ZNHC in the upper nibble
    assign out_flags = {port_flags, 4'b0000};

endmodule

`default_nettype wire

// ==== sim/sm83_ref.svh ====
`ifndef SM83_REF_SVH
`define SM83_REF_SVH

// Expected behavior of the core, kept in model_regs and model_flags

function automatic void model_reset();
    int i;
    begin
        for (i = 0; i < 8; i++)
            model_regs[i] = 8'h00;
        model_flags = `SM83_FLAGS_RESET;
    end
endfunction

// Returns {value, Z, N, H, C}
function automatic logic [11:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
                                        input logic [7:0] b, input logic carry);
    int         cin;
    int         full;
    int         half;
    logic [7:0] value;
    logic       n;
    logic       h;
    logic       c;
    begin
        cin = ((op == `SM83_OP_ADC) || (op == `SM83_OP_SBC)) ? int'(carry) : 0;
        value = 8'h00;
        n = 1'b0;
        h = 1'b0;
        c = 1'b0;
        case (op)
            `SM83_OP_ADD, `SM83_OP_ADC:
            begin
                full  = int'(a) + int'(b) + cin;
                half  = int'(a[3:0]) + int'(b[3:0]) + cin;
                value = full[7:0];
                h     = (half > 15);
                c     = (full > 255);
            end
            `SM83_OP_SUB, `SM83_OP_SBC, `SM83_OP_CP:
            begin
                full  = int'(a) - int'(b) - cin;
                value = full[7:0];
                n     = 1'b1;
                h     = (int'(a[3:0]) < int'(b[3:0]) + cin);   // Borrow from bit 4
                c     = (int'(a) < int'(b) + cin);
            end
            `SM83_OP_AND:
            begin
                value = a & b;
                h     = 1'b1;
            end
            `SM83_OP_XOR: value = a ^ b;
            default:      value = a | b;
        endcase
        alu_ref = {((op == `SM83_OP_CP) ? a : value), (value == 8'h00), n, h, c};
    end
endfunction

// One instruction applied to the model, returns {data, flags}
function automatic logic [11:0] model_execute(input logic [7:0] opcode, input logic [7:0] imm);
    logic [1:0]  grp;
    logic [2:0]  dst;
    logic [2:0]  src;
    logic [7:0]  data;
    logic [11:0] alu_out;
    begin
        grp  = opcode[7:6];
        dst  = opcode[5:3];
        src  = opcode[2:0];
        data = model_regs[`SM83_REG_A];   // No-op reports A
        if (grp == `SM83_GRP_MISC && src == `SM83_REG_HL_IND && dst != `SM83_REG_HL_IND)
        begin
            data = imm;
            model_regs[dst] = data;
        end
        else if (grp == `SM83_GRP_LD && dst != `SM83_REG_HL_IND && src != `SM83_REG_HL_IND
                 && opcode != `SM83_OPC_HALT)
        begin
            data = model_regs[src];
            model_regs[dst] = data;
        end
        else if ((grp == `SM83_GRP_ALU_R && src != `SM83_REG_HL_IND)
                 || (grp == `SM83_GRP_ALU_IMM && src == `SM83_REG_HL_IND))
        begin
            alu_out = alu_ref(dst, model_regs[`SM83_REG_A],
                              (grp == `SM83_GRP_ALU_IMM) ? imm : model_regs[src],
                              model_flags[0]);
            data        = alu_out[11:4];
            model_flags = alu_out[3:0];
            if (dst != `SM83_OP_CP)
                model_regs[`SM83_REG_A] = data;
        end
        model_execute = {data, model_flags};
    end
endfunction

`endif

// ==== sim/sm83_core_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "sm83_params.svh"

module sm83_core_tb;

    localparam int NUM_RANDOM  = 250;
    localparam int CYCLE_LIMIT = 400 * 40;

    logic        clock;
    logic        rst_n;
    logic        in_req;
    logic [7:0]  in_opcode;
    logic [7:0]  in_imm;
    logic        in_ack;
    logic        out_req;
    logic        out_ack;
    logic [7:0]  out_data;
    logic [7:0]  out_flags;

    logic [7:0]  model_regs [0:7];
    logic [3:0]  model_flags;
    logic [11:0] expect_q [$];   // {data, ZNHC}
    int          errors;
    int          sent;
    int          received;
    int          cycles = 0;
    logic        prev_in_req;
    logic        prev_in_ack;
    logic        prev_out_req;
    logic        prev_out_ack;

    `include "sm83_ref.svh"

    sm83_core UUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_opcode (in_opcode),
        .in_imm    (in_imm),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_data  (out_data),
        .out_flags (out_flags)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic log_error(input string msg);
        begin
            errors++;
            $display("%s", msg);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        rand_byte = $urandom_range(0, 255);
    endfunction

    // Any register index except the (HL) slot
    function automatic logic [2:0] pick_reg();
        logic [2:0] r;
        begin
            r = $urandom_range(0, 6);
            pick_reg = (r == 3'd6) ? 3'd7 : r;
        end
    endfunction

    task automatic send_instr(input logic [7:0] opcode, input logic [7:0] imm);
        begin
            expect_q.push_back(model_execute(opcode, imm));
            sent++;
            in_opcode = opcode;
            in_imm    = imm;
            in_req    = 1'b1;
            do @(negedge clock); while (!in_ack);
            in_req    = 1'b0;
            in_opcode = rand_byte();   // Data is free once acknowledged
            in_imm    = rand_byte();
            do @(negedge clock); while (in_ack);
        end
    endtask

    // Output consumer with random ack delays
    initial
    begin
        @(posedge rst_n);
        forever
        begin
            @(negedge clock);
            if (out_req)
            begin
                repeat ($urandom_range(0, 5)) @(negedge clock);
                out_ack = 1'b1;
                do @(negedge clock); while (out_req);
                repeat ($urandom_range(0, 3)) @(negedge clock);
                out_ack = 1'b0;
            end
        end
    end

    // Handshake rules and result compare, on values the DUT sees at the edge
    always @(posedge clock)
    begin
        logic [11:0] expected;
        if (!rst_n)
        begin
            prev_in_req  = 1'b0;
            prev_in_ack  = 1'b0;
            prev_out_req = 1'b0;
            prev_out_ack = 1'b0;
        end
        else
        begin
            if (in_ack && !prev_in_ack)
                assert (prev_in_req)
                else
                    log_error($sformatf("in_ack rose without in_req at %0t", $time));
            if (!in_ack && prev_in_ack)
                assert (!prev_in_req)
                else
                    log_error($sformatf("in_ack fell while in_req was high at %0t", $time));
            if (!out_req && prev_out_req)
                assert (prev_out_ack)
                else
                    log_error($sformatf("out_req fell before out_ack at %0t", $time));
            if (out_req && !prev_out_req)
            begin
                assert (!prev_out_ack)
                else
                    log_error($sformatf("out_req rose while out_ack was still high at %0t",
                                        $time));
                assert (expect_q.size() > 0)
                else
                    log_error($sformatf("Extra result with nothing outstanding at %0t", $time));
                if (expect_q.size() > 0)
                begin
                    expected = expect_q.pop_front();
                    received++;
                    assert (out_data === expected[11:4])
                    else
                        log_error($sformatf("Mismatch at %0t: out_data expected %02h, got %02h",
                                            $time, expected[11:4], out_data));
                    assert (out_flags === {expected[3:0], 4'b0000})
                    else
                        log_error($sformatf("Mismatch at %0t: out_flags expected %02h, got %02h",
                                            $time, {expected[3:0], 4'b0000}, out_flags));
                end
            end
            prev_in_req  = in_req;
            prev_in_ack  = in_ack;
            prev_out_req = out_req;
            prev_out_ack = out_ack;
        end
    end

    always @(posedge clock)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: run still busy after %0d cycles, %0d of %0d results seen",
                     CYCLE_LIMIT, received, sent);
            $display("Verification failed");
            $finish;
        end
    end

    initial
    begin
        int         i;
        logic [2:0] op;
        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_opcode = 8'h00;
        in_imm    = 8'h00;
        out_ack   = 1'b0;
        errors    = 0;
        sent      = 0;
        received  = 0;
        void'($urandom(32'hf8b4));
        model_reset();
        repeat (3) @(negedge clock);
        rst_n = 1'b1;

        send_instr(8'h87, 8'h00);   // ADD A,A from reset

        for (i = 0; i < 8; i++)
        begin
            if (i != 6)
                send_instr({2'b00, i[2:0], 3'b110}, rand_byte());
        end
        for (i = 0; i < 12; i++)
            send_instr({2'b01, pick_reg(), pick_reg()}, rand_byte());

        for (i = 0; i < NUM_RANDOM; i++)
        begin
            op = $urandom_range(0, 7);
            if ($urandom_range(0, 3) == 0)
                send_instr({2'b00, pick_reg(), 3'b110}, rand_byte());
            if ($urandom_range(0, 1) == 0)
                send_instr({2'b10, op, pick_reg()}, rand_byte());
            else
                send_instr({2'b11, op, 3'b110}, rand_byte());
        end

        // Carry chains
        for (i = 0; i < 16; i++)
            send_instr({2'b11, (i < 8) ? `SM83_OP_ADC : `SM83_OP_SBC, 3'b110}, rand_byte());

        send_instr(`SM83_OPC_HALT, rand_byte());
        send_instr(8'h36, rand_byte());   // LD (HL),d8
        for (i = 0; i < 8; i++)
        begin
            send_instr({2'b01, i[2:0], 3'b110}, rand_byte());
            send_instr({2'b01, 3'b110, i[2:0]}, rand_byte());
            send_instr({2'b10, i[2:0], 3'b110}, rand_byte());
            send_instr({2'b00, i[2:0], pick_reg()}, rand_byte());
            send_instr({2'b11, i[2:0], pick_reg()}, rand_byte());
        end

        // Read back every register through A
        send_instr(8'h7f, 8'h00);
        for (i = 0; i < 6; i++)
            send_instr({2'b01, 3'b111, i[2:0]}, 8'h00);

        while (received != sent)
            @(negedge clock);
        repeat (20) @(negedge clock);   // Room for a stray extra result

        $display("Errors: %0d, instructions sent: %0d, results checked: %0d",
                 errors, sent, received);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
+incdir+sim
source/sm83_pkg.sv
source/instr_intake.sv
source/reg_file.sv
source/sm83_alu.sv
source/sm83_execute.sv
source/result_port.sv
source/sm83_core.sv
sim/sm83_core_tb.sv
